//--- testbench/even_pipe_stim.txt
# First data line: ra rb used by every issue. Then one row per cycle:
# unit op rt rw br | src ae be ce ao bo co | valid bits | stall e o | wb: write addr data
0f0f00fffffffffd0000001001020304 01010101000200050000000104030201
3 0 00 0 0 00 00 00 00 00 00 111111 0 0 0 00 0
1 0 10 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
1 1 11 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
1 2 12 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
1 3 13 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
1 4 14 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
2 5 15 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
2 6 16 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
2 7 17 1 0 00 00 00 00 00 00 000000 0 0 0 00 0
0 8 18 1 0 00 00 00 00 00 00 000000 0 0 1 10 10100200000200020000001105050505
0 9 19 1 0 00 00 00 00 00 00 000000 0 0 1 11 0e0dfffefffdfff80000000ffcff0103
1 0 1a 1 0 00 00 00 00 00 00 000000 0 0 1 12 01010001000200050000000000020200
0 8 1b 1 0 00 00 00 00 00 00 000000 0 0 1 13 0f0f01fffffffffd0000001105030305
2 5 1c 1 0 00 00 00 00 00 00 000000 0 0 1 14 0e0e01fefffdfff80000001105010105
1 4 1d 1 0 00 00 00 00 00 00 000000 0 0 1 15 04040008080808070000000101010201
1 3 1e 0 0 00 00 00 00 00 00 000000 0 0 1 16 0e0e01fefffdfff80000000f03010103
3 0 1f 1 0 00 00 00 00 00 00 000000 0 0 1 17 011d000403fa000700100001000a000a
0 9 20 1 0 00 00 00 00 00 00 000000 0 0 1 18 0000ffff0004fff10000001000060b04
2 7 21 1 0 00 00 00 00 00 00 000000 0 0 1 19 0000fffffffffff10000001000060b04
1 0 22 1 1 00 00 00 00 00 00 000000 0 0 1 1a 10100200000200020000001105050505
3 0 00 0 0 22 21 9d 1d 00 00 111100 0 1 1 1b 0000ffff0004fff10000001000060b04
3 0 00 0 0 1d 1e 20 20 00 00 110100 0 1 1 1c 04040008080808070000000101010201
1 0 30 1 0 30 00 00 1f 00 00 100100 1 1 1 1d 0e0e01fefffdfff80000001105010105
3 0 00 0 0 30 00 00 1f 00 22 100101 1 0 0 00 0
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 0 00 0
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 1 20 0000fffffffffff10000001000060b04
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 0 00 0
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 0 00 0
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 0 00 0
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 0 00 0
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 1 30 10100200000200020000001105050505
3 0 00 0 0 00 00 00 00 00 00 000000 0 0 0 00 0

//--- even_pipe.f
+incdir+logic
logic/even_pipe_pkg.sv
logic/fixed_unit.sv
logic/byte_unit.sv
logic/multiply_unit.sv
logic/writeback_stager.sv
logic/raw_hazard_check.sv
logic/even_pipe.sv
testbench/even_pipe_checker.sv
testbench/even_pipe_tb.sv

//--- Bender.yml
package:
  name: even_pipe

sources:
  - include_dirs:
      - logic
    files:
      - logic/even_pipe_pkg.sv
      - logic/fixed_unit.sv
      - logic/byte_unit.sv
      - logic/multiply_unit.sv
      - logic/writeback_stager.sv
      - logic/raw_hazard_check.sv
      - logic/even_pipe.sv
      - target: test
        files:
          - testbench/even_pipe_checker.sv
          - testbench/even_pipe_tb.sv

//--- testbench/even_pipe_tb.sv
`include "even_pipe_defs.svh"

module even_pipe_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import even_pipe_pkg::*;

	localparam int MAX_ROWS = 200;

	logic                                     clk;
	logic                                     reset;
	opcode_t                                  op;
	unit_t                                    unit;
	logic [`EP_ADDR_W-1:0]                    rt_addr;
	logic [`EP_DATA_W-1:0]                    ra;
	logic [`EP_DATA_W-1:0]                    rb;
	logic                                     reg_write;
	logic                                     branch_taken;
	logic [`EP_SRC_ADDR_W-1:0]                ra_even_addr, rb_even_addr, rc_even_addr;
	logic [`EP_SRC_ADDR_W-1:0]                ra_odd_addr, rb_odd_addr, rc_odd_addr;
	logic                                     ra_even_valid, rb_even_valid, rc_even_valid;
	logic                                     ra_odd_valid, rb_odd_valid, rc_odd_valid;
	logic [`EP_DATA_W-1:0]                    rt_wb;
	logic [`EP_ADDR_W-1:0]                    rt_addr_wb;
	logic                                     reg_write_wb;
	logic [`EP_WB_STAGES-1:1][`EP_DATA_W-1:0] fw_data;
	logic [`EP_WB_STAGES-1:1][`EP_ADDR_W-1:0] fw_addr;
	logic [`EP_WB_STAGES-1:1]                 fw_write;
	logic                                     stall_even;
	logic                                     stall_odd;

	logic                  exp_stall_even, exp_stall_odd;	// Expected values of the current row
	logic                  exp_write_wb;
	logic [`EP_ADDR_W-1:0] exp_addr_wb;
	logic [`EP_DATA_W-1:0] exp_rt_wb;
	logic                  stim_active;
	logic                  stim_done;
	logic                  file_error;
	int                    rows;
	int                    fd;
	int                    stall_errors, wb_errors, fw_errors;
	logic                  timed_out, finished;

	always #4 clk = ~clk;

	even_pipe u_even_pipe (.*);

	even_pipe_checker u_checker (
		.clk(clk), .active(stim_active), .stim_done(stim_done),
		.exp_stall_even(exp_stall_even), .exp_stall_odd(exp_stall_odd),
		.exp_write_wb(exp_write_wb), .exp_addr_wb(exp_addr_wb), .exp_rt_wb(exp_rt_wb),
		.stall_even(stall_even), .stall_odd(stall_odd), .reg_write_wb(reg_write_wb),
		.rt_addr_wb(rt_addr_wb), .rt_wb(rt_wb),
		.fw_data(fw_data), .fw_addr(fw_addr), .fw_write(fw_write),
		.stall_errors(stall_errors), .wb_errors(wb_errors), .fw_errors(fw_errors),
		.timed_out(timed_out), .finished(finished)
	);

	// Skips comment lines and empty lines
	task automatic next_data_line(output string line, output bit found);
		string text;
		int    n;
		found = 0;
		while (!found && !$feof(fd)) begin
			n = $fgets(text, fd);
			if (n > 1 && text.getc(0) != 8'h23) begin
				line  = text;
				found = 1;
			end
		end
	endtask

	task automatic apply_row(input string line, output bit ok);
		int         n;
		logic [1:0] u;
		logic [3:0] o;
		logic [5:0] vld;
		n = $sscanf(line, "%h %h %h %b %b %h %h %h %h %h %h %b %b %b %b %h %h",
			u, o, rt_addr, reg_write, branch_taken,
			ra_even_addr, rb_even_addr, rc_even_addr, ra_odd_addr, rb_odd_addr, rc_odd_addr,
			vld, exp_stall_even, exp_stall_odd, exp_write_wb, exp_addr_wb, exp_rt_wb);
		unit = unit_t'(u);
		op   = opcode_t'(o);
		{ra_even_valid, rb_even_valid, rc_even_valid} = vld[5:3];
		{ra_odd_valid, rb_odd_valid, rc_odd_valid}    = vld[2:0];
		ok = (n == 17);
	endtask

	initial begin
		string text;
		bit    found;
		bit    ok;
		bit    more;
		clk = 1'b0;
		reset = 1'b1;
		op = OP_ADD;
		unit = unit_t'(2'd3);	// Reserved code issues nothing
		rt_addr = '0;
		ra = '0;
		rb = '0;
		reg_write = 1'b0;
		branch_taken = 1'b0;
		{ra_even_addr, rb_even_addr, rc_even_addr} = '0;
		{ra_odd_addr, rb_odd_addr, rc_odd_addr} = '0;
		{ra_even_valid, rb_even_valid, rc_even_valid} = '0;
		{ra_odd_valid, rb_odd_valid, rc_odd_valid} = '0;
		{exp_stall_even, exp_stall_odd, exp_write_wb} = '0;
		exp_addr_wb = '0;
		exp_rt_wb = '0;
		stim_active = 1'b0;
		stim_done = 1'b0;
		file_error = 1'b0;
		rows = 0;
		fd = $fopen("testbench/even_pipe_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file testbench/even_pipe_stim.txt");
			file_error = 1'b1;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (!file_error) begin
			next_data_line(text, found);	// First data line holds ra and rb
			if (!found || $sscanf(text, "%h %h", ra, rb) != 2) begin
				$display("The operand line of the stimulus file is missing or malformed");
				file_error = 1'b1;
			end
		end
		more = 1;
		while (more && !file_error && rows < MAX_ROWS) begin
			next_data_line(text, found);
			if (!found) begin
				more = 0;
			end else begin
				apply_row(text, ok);
				if (!ok) begin
					$display("Stimulus row %0d could not be parsed", rows);
					file_error = 1'b1;
				end else begin
					stim_active = 1'b1;
					rows++;
					@(negedge clk);
				end
			end
		end
		stim_active = 1'b0;
		unit = unit_t'(2'd3);
		reg_write = 1'b0;
		stim_done = 1'b1;
		if (fd != 0)
			$fclose(fd);
	end

	initial begin
		int cyc;
		cyc = 0;
		while (finished !== 1'b1 && cyc < 400) begin
			@(posedge clk);
			cyc++;
		end
		if (finished !== 1'b1)
			$display("The checker did not finish within 400 cycles");
		$display("Errors: stall %0d, writeback %0d, forwarding %0d, rows applied %0d",
			stall_errors, wb_errors, fw_errors, rows);
		if (finished === 1'b1 && timed_out !== 1'b1 && !file_error && rows > 0 &&
			stall_errors + wb_errors + fw_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- testbench/even_pipe_checker.sv
`include "even_pipe_defs.svh"

module even_pipe_checker (
	input  logic                                     clk,
	input  logic                                     active,
	input  logic                                     stim_done,
	input  logic                                     exp_stall_even,
	input  logic                                     exp_stall_odd,
	input  logic                                     exp_write_wb,
	input  logic [`EP_ADDR_W-1:0]                    exp_addr_wb,
	input  logic [`EP_DATA_W-1:0]                    exp_rt_wb,
	input  logic                                     stall_even,
	input  logic                                     stall_odd,
	input  logic                                     reg_write_wb,
	input  logic [`EP_ADDR_W-1:0]                    rt_addr_wb,
	input  logic [`EP_DATA_W-1:0]                    rt_wb,
	input  logic [`EP_WB_STAGES-1:1][`EP_DATA_W-1:0] fw_data,
	input  logic [`EP_WB_STAGES-1:1][`EP_ADDR_W-1:0] fw_addr,
	input  logic [`EP_WB_STAGES-1:1]                 fw_write,
	output int                                       stall_errors,
	output int                                       wb_errors,
	output int                                       fw_errors,
	output logic                                     timed_out,
	output logic                                     finished
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LAST = `EP_WB_STAGES - 1;

	int                    stall_count = 0;
	int                    wb_count = 0;
	int                    fw_count = 0;
	logic                  timed_out_q = 1'b0;
	logic                  finished_q = 1'b0;
	logic                  prev_fw_write;	// Entry 6 as sampled one edge back
	logic [`EP_ADDR_W-1:0] prev_fw_addr;
	logic [`EP_DATA_W-1:0] prev_fw_data;

	assign stall_errors = stall_count;
	assign wb_errors    = wb_count;
	assign fw_errors    = fw_count;
	assign timed_out    = timed_out_q;
	assign finished     = finished_q;

	// Registers update after this block reads them at the same edge
	always @(posedge clk) begin
		if (active) begin
			if (stall_even !== exp_stall_even) begin
				$display("Fail stall_even: expected %h, got %h at %0t",
					exp_stall_even, stall_even, $time);
				stall_count++;
			end
			if (stall_odd !== exp_stall_odd) begin
				$display("Fail stall_odd: expected %h, got %h at %0t",
					exp_stall_odd, stall_odd, $time);
				stall_count++;
			end
			if (reg_write_wb !== exp_write_wb) begin
				$display("Fail reg_write_wb: expected %h, got %h at %0t",
					exp_write_wb, reg_write_wb, $time);
				wb_count++;
			end
			if (exp_write_wb && rt_addr_wb !== exp_addr_wb) begin
				$display("Fail rt_addr_wb: expected %h, got %h at %0t",
					exp_addr_wb, rt_addr_wb, $time);
				wb_count++;
			end
			if (exp_write_wb && rt_wb !== exp_rt_wb) begin
				$display("Fail rt_wb: expected %h, got %h at %0t",
					exp_rt_wb, rt_wb, $time);
				wb_count++;
			end
			if (prev_fw_write !== exp_write_wb) begin
				$display("Fail fw_write[6]: expected %h, got %h at %0t",
					exp_write_wb, prev_fw_write, $time);
				fw_count++;
			end
			if (exp_write_wb && prev_fw_addr !== exp_addr_wb) begin
				$display("Fail fw_addr[6]: expected %h, got %h at %0t",
					exp_addr_wb, prev_fw_addr, $time);
				fw_count++;
			end
			if (exp_write_wb && prev_fw_data !== exp_rt_wb) begin
				$display("Fail fw_data[6]: expected %h, got %h at %0t",
					exp_rt_wb, prev_fw_data, $time);
				fw_count++;
			end
			if (fw_write[1] !== 1'b0) begin	// Fed by empty entry 0
				$display("Fail fw_write[1]: expected 0, got %h at %0t",
					fw_write[1], $time);
				fw_count++;
			end
		end
		prev_fw_write = fw_write[LAST];
		prev_fw_addr  = fw_addr[LAST];
		prev_fw_data  = fw_data[LAST];
	end

	initial begin
		int cyc;
		cyc = 0;
		while (stim_done !== 1'b1 && cyc < 200) begin
			@(posedge clk);
			cyc++;
		end
		if (stim_done !== 1'b1) begin
			$display("Timeout: the end of the stimulus file was not reached within 200 cycles");
			timed_out_q = 1'b1;
		end
		finished_q = 1'b1;
	end

endmodule

//--- logic/even_pipe.sv
`include "even_pipe_defs.svh"

module even_pipe (
	input  logic                                    clk,
	input  logic                                    reset,
	input  even_pipe_pkg::opcode_t                  op,
	input  even_pipe_pkg::unit_t                    unit,
	input  logic [`EP_ADDR_W-1:0]                   rt_addr,
	input  logic [`EP_DATA_W-1:0]                   ra,
	input  logic [`EP_DATA_W-1:0]                   rb,
	input  logic                                    reg_write,
	input  logic                                    branch_taken,
	input  logic [`EP_SRC_ADDR_W-1:0]               ra_even_addr,
	input  logic [`EP_SRC_ADDR_W-1:0]               rb_even_addr,
	input  logic [`EP_SRC_ADDR_W-1:0]               rc_even_addr,
	input  logic [`EP_SRC_ADDR_W-1:0]               ra_odd_addr,
	input  logic [`EP_SRC_ADDR_W-1:0]               rb_odd_addr,
	input  logic [`EP_SRC_ADDR_W-1:0]               rc_odd_addr,
	input  logic                                    ra_even_valid,
	input  logic                                    rb_even_valid,
	input  logic                                    rc_even_valid,
	input  logic                                    ra_odd_valid,
	input  logic                                    rb_odd_valid,
	input  logic                                    rc_odd_valid,
	output logic [`EP_DATA_W-1:0]                   rt_wb,
	output logic [`EP_ADDR_W-1:0]                   rt_addr_wb,
	output logic                                    reg_write_wb,
	output logic [`EP_WB_STAGES-1:1][`EP_DATA_W-1:0] fw_data,
	output logic [`EP_WB_STAGES-1:1][`EP_ADDR_W-1:0] fw_addr,
	output logic [`EP_WB_STAGES-1:1]                 fw_write,
	output logic                                    stall_even,
	output logic                                    stall_odd
);
	import even_pipe_pkg::*;

	opcode_t               fx_op, byte_op, mpy_op;
	logic                  fx_valid, byte_valid, mpy_valid;
	logic                  fx_reg_write, byte_reg_write, mpy_reg_write;
	logic [`EP_DATA_W-1:0] fx_result, byte_result, mpy_result;
	logic [`EP_ADDR_W-1:0] fx_addr, byte_addr, mpy_addr;
	logic                  fx_write, byte_write, mpy_write;

	// Idle units see valid low
	always_comb begin
		fx_op          = OP_ADD;
		byte_op        = OP_ADD;
		mpy_op         = OP_ADD;
		fx_valid       = 1'b0;
		byte_valid     = 1'b0;
		mpy_valid      = 1'b0;
		fx_reg_write   = 1'b0;
		byte_reg_write = 1'b0;
		mpy_reg_write  = 1'b0;
		case (unit)
			UNIT_FX: begin
				fx_op        = op;
				fx_valid     = 1'b1;
				fx_reg_write = reg_write;
			end
			UNIT_BYTE: begin
				byte_op        = op;
				byte_valid     = 1'b1;
				byte_reg_write = reg_write;
			end
			UNIT_MPY: begin
				mpy_op        = op;
				mpy_valid     = 1'b1;
				mpy_reg_write = reg_write;
			end
			default: ;	// Reserved code issues nothing
		endcase
	end

	fixed_unit u_fixed_unit (
		.clk(clk), .reset(reset), .valid(fx_valid), .op(fx_op), .rt_addr(rt_addr),
		.reg_write(fx_reg_write), .branch_taken(branch_taken), .ra(ra), .rb(rb),
		.result(fx_result), .result_addr(fx_addr), .result_write(fx_write)
	);

	byte_unit u_byte_unit (
		.clk(clk), .reset(reset), .valid(byte_valid), .op(byte_op), .rt_addr(rt_addr),
		.reg_write(byte_reg_write), .branch_taken(branch_taken), .ra(ra), .rb(rb),
		.result(byte_result), .result_addr(byte_addr), .result_write(byte_write)
	);

	multiply_unit u_multiply_unit (
		.clk(clk), .reset(reset), .valid(mpy_valid), .op(mpy_op), .rt_addr(rt_addr),
		.reg_write(mpy_reg_write), .branch_taken(branch_taken), .ra(ra), .rb(rb),
		.result(mpy_result), .result_addr(mpy_addr), .result_write(mpy_write)
	);

	writeback_stager u_writeback_stager (
		.clk(clk), .reset(reset),
		.fx_result(fx_result), .fx_addr(fx_addr), .fx_write(fx_write),
		.byte_result(byte_result), .byte_addr(byte_addr), .byte_write(byte_write),
		.mpy_result(mpy_result), .mpy_addr(mpy_addr), .mpy_write(mpy_write),
		.rt_wb(rt_wb), .rt_addr_wb(rt_addr_wb), .reg_write_wb(reg_write_wb),
		.fw_data(fw_data), .fw_addr(fw_addr), .fw_write(fw_write)
	);

	raw_hazard_check u_raw_hazard_check (
		.clk(clk), .reset(reset), .rt_addr(rt_addr), .reg_write(reg_write),
		.branch_taken(branch_taken),
		.ra_even_addr(ra_even_addr), .rb_even_addr(rb_even_addr),
		.rc_even_addr(rc_even_addr), .ra_odd_addr(ra_odd_addr),
		.rb_odd_addr(rb_odd_addr), .rc_odd_addr(rc_odd_addr),
		.ra_even_valid(ra_even_valid), .rb_even_valid(rb_even_valid),
		.rc_even_valid(rc_even_valid), .ra_odd_valid(ra_odd_valid),
		.rb_odd_valid(rb_odd_valid), .rc_odd_valid(rc_odd_valid),
		.stall_even(stall_even), .stall_odd(stall_odd)
	);

endmodule

//--- logic/raw_hazard_check.sv
`include "even_pipe_defs.svh"

module raw_hazard_check (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`EP_ADDR_W-1:0]     rt_addr,
	input  logic                      reg_write,
	input  logic                      branch_taken,
	input  logic [`EP_SRC_ADDR_W-1:0] ra_even_addr,
	input  logic [`EP_SRC_ADDR_W-1:0] rb_even_addr,
	input  logic [`EP_SRC_ADDR_W-1:0] rc_even_addr,
	input  logic [`EP_SRC_ADDR_W-1:0] ra_odd_addr,
	input  logic [`EP_SRC_ADDR_W-1:0] rb_odd_addr,
	input  logic [`EP_SRC_ADDR_W-1:0] rc_odd_addr,
	input  logic                      ra_even_valid,
	input  logic                      rb_even_valid,
	input  logic                      rc_even_valid,
	input  logic                      ra_odd_valid,
	input  logic                      rb_odd_valid,
	input  logic                      rc_odd_valid,
	output logic                      stall_even,
	output logic                      stall_odd
);
	import even_pipe_pkg::*;

	localparam int N = `EP_WB_STAGES;

	logic [N-1:1][`EP_ADDR_W-1:0] rec_addr;	// Issued 1 to 6 cycles ago
	logic [N-1:1]                  rec_write;
	logic [N-1:0][`EP_ADDR_W-1:0] pend_addr;	// Current issue at index 0
	logic [N-1:0]                  pend_write;
	logic                          hit_even;
	logic                          hit_odd;

	function automatic logic src_match(
		input logic [`EP_SRC_ADDR_W-1:0] src,
		input logic                      src_valid,
		input logic [`EP_ADDR_W-1:0]     dst
	);
		return src_valid && !src[`EP_SRC_ADDR_W-1] && (src[`EP_ADDR_W-1:0] == dst);
	endfunction

	always_ff @(posedge clk) begin
		rec_addr[1] <= rt_addr;
		for (int k = 2; k < N; k++) begin
			rec_addr[k] <= rec_addr[k-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rec_write <= '0;
		end else begin
			rec_write[1] <= reg_write & ~branch_taken;
			rec_write[2] <= rec_write[1] & ~branch_taken;	// Same kill as the units
			for (int k = 3; k < N; k++) begin
				rec_write[k] <= rec_write[k-1];
			end
		end
	end

	assign pend_addr  = {rec_addr, rt_addr};
	assign pend_write = {rec_write, reg_write};

	always_comb begin
		hit_even = 1'b0;
		hit_odd  = 1'b0;
		for (int k = 0; k < N; k++) begin
			if (pend_write[k]) begin
				hit_even |= src_match(ra_even_addr, ra_even_valid, pend_addr[k]) |
				            src_match(rb_even_addr, rb_even_valid, pend_addr[k]) |
				            src_match(rc_even_addr, rc_even_valid, pend_addr[k]);
				hit_odd  |= src_match(ra_odd_addr, ra_odd_valid, pend_addr[k]) |
				            src_match(rb_odd_addr, rb_odd_valid, pend_addr[k]) |
				            src_match(rc_odd_addr, rc_odd_valid, pend_addr[k]);
			end
		end
	end

	assign stall_even = hit_even & ~reset;
	assign stall_odd  = hit_odd & ~reset;

endmodule

//--- logic/writeback_stager.sv
`include "even_pipe_defs.svh"

module writeback_stager (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic [`EP_DATA_W-1:0]                   fx_result,
	input  logic [`EP_ADDR_W-1:0]                   fx_addr,
	input  logic                                    fx_write,
	input  logic [`EP_DATA_W-1:0]                   byte_result,
	input  logic [`EP_ADDR_W-1:0]                   byte_addr,
	input  logic                                    byte_write,
	input  logic [`EP_DATA_W-1:0]                   mpy_result,
	input  logic [`EP_ADDR_W-1:0]                   mpy_addr,
	input  logic                                    mpy_write,
	output logic [`EP_DATA_W-1:0]                   rt_wb,
	output logic [`EP_ADDR_W-1:0]                   rt_addr_wb,
	output logic                                    reg_write_wb,
	output logic [`EP_WB_STAGES-1:1][`EP_DATA_W-1:0] fw_data,
	output logic [`EP_WB_STAGES-1:1][`EP_ADDR_W-1:0] fw_addr,
	output logic [`EP_WB_STAGES-1:1]                 fw_write
);
	import even_pipe_pkg::*;

	localparam int N = `EP_WB_STAGES;

	// Insertion points, entry k holds the instruction issued k cycles ago
	logic [N-1:2][`EP_DATA_W-1:0] ins_data;
	logic [N-1:2][`EP_ADDR_W-1:0] ins_addr;
	logic [N-1:2]                  ins_write;

	always_comb begin
		ins_data  = '0;
		ins_addr  = '0;
		ins_write = '0;
		ins_data[`EP_FX_LAT]    = fx_result;
		ins_addr[`EP_FX_LAT]    = fx_addr;
		ins_write[`EP_FX_LAT]   = fx_write;
		ins_data[`EP_BYTE_LAT]  = byte_result;
		ins_addr[`EP_BYTE_LAT]  = byte_addr;
		ins_write[`EP_BYTE_LAT] = byte_write;
		ins_data[`EP_MPY_LAT]   = mpy_result;
		ins_addr[`EP_MPY_LAT]   = mpy_addr;
		ins_write[`EP_MPY_LAT]  = mpy_write;
	end

	// One issue per cycle, so an insert never meets a live entry
	always_ff @(posedge clk) begin
		if (reset) begin
			fw_write     <= '0;
			reg_write_wb <= 1'b0;
		end else begin
			fw_write[1] <= 1'b0;	// Shifted in from empty entry 0
			for (int k = 2; k < N; k++) begin
				fw_write[k] <= ins_write[k] | fw_write[k-1];
			end
			reg_write_wb <= fw_write[N-1];
		end
	end

	always_ff @(posedge clk) begin
		fw_data[1] <= '0;
		fw_addr[1] <= '0;
		for (int k = 2; k < N; k++) begin
			if (ins_write[k]) begin
				fw_data[k] <= ins_data[k];
				fw_addr[k] <= ins_addr[k];
			end else begin
				fw_data[k] <= fw_data[k-1];
				fw_addr[k] <= fw_addr[k-1];
			end
		end
		rt_wb      <= fw_data[N-1];	// Output register after entry 6
		rt_addr_wb <= fw_addr[N-1];
	end

endmodule

//--- logic/multiply_unit.sv
`include "even_pipe_defs.svh"

module multiply_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   valid,
	input  even_pipe_pkg::opcode_t op,
	input  logic [`EP_ADDR_W-1:0]  rt_addr,
	input  logic                   reg_write,
	input  logic                   branch_taken,
	input  logic [`EP_DATA_W-1:0]  ra,
	input  logic [`EP_DATA_W-1:0]  rb,
	output logic [`EP_DATA_W-1:0]  result,
	output logic [`EP_ADDR_W-1:0]  result_addr,
	output logic                   result_write
);
	import even_pipe_pkg::*;

	localparam int LAT   = `EP_MPY_LAT;
	localparam int LANES = `EP_DATA_W / 32;

	logic                           s1_signed;
	logic [LANES*16-1:0]            s1_a;	// Low halfword of each ra word
	logic [LANES*16-1:0]            s1_b;
	logic [`EP_DATA_W-1:0]          lane_prod;
	logic [LAT:2][`EP_DATA_W-1:0]  data_q;
	logic [LAT:1][`EP_ADDR_W-1:0]  addr_q;
	logic [LAT:1]                   write_q;

	// Extending by one bit covers both signed and unsigned products
	always_comb begin
		logic signed [16:0] a_ext;
		logic signed [16:0] b_ext;
		logic signed [33:0] prod;
		for (int i = 0; i < LANES; i++) begin
			a_ext = {s1_signed & s1_a[16*i+15], s1_a[16*i +: 16]};
			b_ext = {s1_signed & s1_b[16*i+15], s1_b[16*i +: 16]};
			prod  = a_ext * b_ext;
			lane_prod[32*i +: 32] = prod[31:0];
		end
	end

	always_ff @(posedge clk) begin
		s1_signed <= (op == OP_MPYS);
		for (int i = 0; i < LANES; i++) begin
			s1_a[16*i +: 16] <= ra[32*i +: 16];
			s1_b[16*i +: 16] <= rb[32*i +: 16];
		end
		data_q[2] <= lane_prod;
		for (int k = 3; k <= LAT; k++) begin
			data_q[k] <= data_q[k-1];	// Plain delay stages
		end
		addr_q[1] <= rt_addr;
		for (int k = 2; k <= LAT; k++) begin
			addr_q[k] <= addr_q[k-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			write_q <= '0;
		end else begin
			write_q[1] <= valid & reg_write & ~branch_taken;
			write_q[2] <= write_q[1] & ~branch_taken;
			for (int k = 3; k <= LAT; k++) begin
				write_q[k] <= write_q[k-1];
			end
		end
	end

	assign result       = data_q[LAT];
	assign result_addr  = addr_q[LAT];
	assign result_write = write_q[LAT];

endmodule

//--- logic/byte_unit.sv
`include "even_pipe_defs.svh"

module byte_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   valid,
	input  even_pipe_pkg::opcode_t op,
	input  logic [`EP_ADDR_W-1:0]  rt_addr,
	input  logic                   reg_write,
	input  logic                   branch_taken,
	input  logic [`EP_DATA_W-1:0]  ra,
	input  logic [`EP_DATA_W-1:0]  rb,
	output logic [`EP_DATA_W-1:0]  result,
	output logic [`EP_ADDR_W-1:0]  result_addr,
	output logic                   result_write
);
	import even_pipe_pkg::*;

	localparam int LAT    = `EP_BYTE_LAT;
	localparam int NBYTES = `EP_DATA_W / 8;
	localparam int LANES  = `EP_DATA_W / 32;

	opcode_t                        s1_op;
	opcode_t                        s2_op;
	logic [`EP_DATA_W-1:0]          s1_ra;
	logic [`EP_DATA_W-1:0]          s1_rb;
	logic [`EP_DATA_W-1:0]          cnt_b;	// Stage 2 inputs
	logic [`EP_DATA_W-1:0]          absd_b;
	logic [`EP_DATA_W-1:0]          sum_w;
	logic [`EP_DATA_W-1:0]          s2_cnt;
	logic [`EP_DATA_W-1:0]          s2_absd;
	logic [`EP_DATA_W-1:0]          s2_sum;
	logic [`EP_DATA_W-1:0]          s3_data;
	logic [LAT:1][`EP_ADDR_W-1:0]  addr_q;
	logic [LAT:1]                   write_q;

	always_comb begin
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] sum_a;
		logic [15:0] sum_b;
		for (int i = 0; i < NBYTES; i++) begin
			a = s1_ra[8*i +: 8];
			b = s1_rb[8*i +: 8];
			cnt_b[8*i +: 8]  = 8'($countones(a));
			absd_b[8*i +: 8] = (a > b) ? a - b : b - a;
		end
		// ra byte sum goes high, rb byte sum goes low
		for (int w = 0; w < LANES; w++) begin
			sum_a = '0;
			sum_b = '0;
			for (int j = 0; j < 4; j++) begin
				sum_a = sum_a + 16'(s1_ra[32*w + 8*j +: 8]);
				sum_b = sum_b + 16'(s1_rb[32*w + 8*j +: 8]);
			end
			sum_w[32*w +: 32] = {sum_a, sum_b};
		end
	end

	always_ff @(posedge clk) begin
		s1_op   <= op;	// Stage 1 operands
		s1_ra   <= ra;
		s1_rb   <= rb;
		s2_op   <= s1_op;	// Stage 2 per-byte results
		s2_cnt  <= cnt_b;
		s2_absd <= absd_b;
		s2_sum  <= sum_w;
		case (s2_op)
			OP_CNTB:  s3_data <= s2_cnt;
			OP_ABSDB: s3_data <= s2_absd;
			OP_SUMB:  s3_data <= s2_sum;
			default:  s3_data <= '0;
		endcase
		result    <= s3_data;	// Stage 4
		addr_q[1] <= rt_addr;
		for (int k = 2; k <= LAT; k++) begin
			addr_q[k] <= addr_q[k-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			write_q <= '0;
		end else begin
			write_q[1] <= valid & reg_write & ~branch_taken;
			write_q[2] <= write_q[1] & ~branch_taken;	// Previous issue also cancelled
			for (int k = 3; k <= LAT; k++) begin
				write_q[k] <= write_q[k-1];
			end
		end
	end

	assign result_addr  = addr_q[LAT];
	assign result_write = write_q[LAT];

endmodule

//--- logic/fixed_unit.sv
`include "even_pipe_defs.svh"

module fixed_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   valid,
	input  even_pipe_pkg::opcode_t op,
	input  logic [`EP_ADDR_W-1:0]  rt_addr,
	input  logic                   reg_write,
	input  logic                   branch_taken,
	input  logic [`EP_DATA_W-1:0]  ra,
	input  logic [`EP_DATA_W-1:0]  rb,
	output logic [`EP_DATA_W-1:0]  result,
	output logic [`EP_ADDR_W-1:0]  result_addr,
	output logic                   result_write
);
	import even_pipe_pkg::*;

	localparam int LAT   = `EP_FX_LAT;
	localparam int LANES = `EP_DATA_W / 32;

	logic [`EP_DATA_W-1:0]          lane_res;	// Computed from the issue inputs
	logic [LAT:1][`EP_DATA_W-1:0]  data_q;
	logic [LAT:1][`EP_ADDR_W-1:0]  addr_q;
	logic [LAT:1]                   write_q;

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			case (op)
				OP_ADD:  lane_res[32*i +: 32] = ra[32*i +: 32] + rb[32*i +: 32];
				OP_SUB:  lane_res[32*i +: 32] = ra[32*i +: 32] - rb[32*i +: 32];
				OP_AND:  lane_res[32*i +: 32] = ra[32*i +: 32] & rb[32*i +: 32];
				OP_OR:   lane_res[32*i +: 32] = ra[32*i +: 32] | rb[32*i +: 32];
				OP_XOR:  lane_res[32*i +: 32] = ra[32*i +: 32] ^ rb[32*i +: 32];
				default: lane_res[32*i +: 32] = '0;	// Not a fixed unit op
			endcase
		end
	end

	always_ff @(posedge clk) begin
		data_q[1] <= lane_res;
		addr_q[1] <= rt_addr;
		for (int k = 2; k <= LAT; k++) begin
			data_q[k] <= data_q[k-1];
			addr_q[k] <= addr_q[k-1];
		end
	end

	// A taken branch kills the issuing instruction and the one before it
	always_ff @(posedge clk) begin
		if (reset) begin
			write_q <= '0;
		end else begin
			write_q[1] <= valid & reg_write & ~branch_taken;
			write_q[2] <= write_q[1] & ~branch_taken;
			for (int k = 3; k <= LAT; k++) begin
				write_q[k] <= write_q[k-1];
			end
		end
	end

	assign result       = data_q[LAT];
	assign result_addr  = addr_q[LAT];
	assign result_write = write_q[LAT];

endmodule

//--- logic/even_pipe_pkg.sv
package even_pipe_pkg;

	// Execution unit select, code 2'd3 is reserved and issues nothing
	typedef enum logic [1:0] {
		UNIT_MPY  = 2'd0,	// 16x16 word multiply
		UNIT_FX   = 2'd1,	// Simple fixed point
		UNIT_BYTE = 2'd2	// Byte ops
	} unit_t;

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,	// Word add
		OP_SUB   = 4'd1,	// Word subtract, ra - rb
		OP_AND   = 4'd2,
		OP_OR    = 4'd3,
		OP_XOR   = 4'd4,
		OP_CNTB  = 4'd5,	// Ones count per byte
		OP_ABSDB = 4'd6,	// Absolute difference per byte
		OP_SUMB  = 4'd7,	// Byte sums per word
		OP_MPYU  = 4'd8,	// Unsigned low halfword multiply
		OP_MPYS  = 4'd9	// Signed low halfword multiply
	} opcode_t;

endpackage

//--- logic/even_pipe_defs.svh
`ifndef EVEN_PIPE_DEFS_SVH
`define EVEN_PIPE_DEFS_SVH

// Operand and result width, four 32-bit words
`define EP_DATA_W 128

// Register file address width
`define EP_ADDR_W 7

// Issue slot source address, top bit set means no register
`define EP_SRC_ADDR_W 8

// Unit latencies in cycles
`define EP_FX_LAT 2
`define EP_BYTE_LAT 4
`define EP_MPY_LAT 6

// Issue to writeback latency, also the staging chain depth
`define EP_WB_STAGES 7

`endif
